//--- hw/bus_pkg.sv
// shared types and constants for the core memory bus and its AXI4 link
package bus_pkg;

	// ========================================
	// bus widths
	// ========================================

	// byte address as issued by the core and cache
	typedef logic [31:0] addr_t;
	// one bus word
	typedef logic [31:0] word_t;
	// byte enables, bit n covers byte lane n
	typedef logic [3:0] strb_t;
	// AXI burst length field, beats minus one
	typedef logic [7:0] len_t;
	// AXI burst type field
	typedef logic [1:0] burst_t;

	// ========================================
	// burst encodings
	// ========================================

	localparam burst_t BURST_INCR = 2'b01;
	localparam burst_t BURST_WRAP = 2'b10;

	// words per cache line fill
	localparam int LINE_WORDS = 4;

	// bridge FSM, one transaction in flight at a time
	typedef enum logic [2:0] {
		IDLE, WR_ADDR, WR_DATA, WR_RESP, RD_ADDR, RD_DATA
	} bridge_state_t;

endpackage

//--- hw/core_write_buffer.sv
// one-entry posted write buffer between the core port and the AXI bridge
`timescale 1ns/1ps

module core_write_buffer
	import bus_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_rst,
	// core side
	input  logic  i_select,
	input  logic  i_write_enable,
	input  addr_t i_address,
	input  word_t i_write_data,
	input  strb_t i_byte_enable,
	output logic  o_write_stall,
	// bridge side, valid/ready
	input  logic  i_wb_ready,
	output logic  o_wb_valid,
	output addr_t o_wb_addr,
	output word_t o_wb_data,
	output strb_t o_wb_strb
);

	logic  write_req;
	logic  entry_leaving;
	logic  accept;
	logic  r_valid;
	addr_t r_addr;
	word_t r_data;
	strb_t r_strb;

	// reads pass straight by, only writes land here
	assign write_req = i_select & i_write_enable;
	// entry goes to the bridge on the valid/ready cycle
	assign entry_leaving = r_valid & i_wb_ready;
	// empty, or the old entry drains in this same cycle
	assign accept = write_req & (~r_valid | entry_leaving);
	// hold the core only when full and nothing leaves
	assign o_write_stall = write_req & r_valid & ~i_wb_ready;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_valid <= 1'b0;
		end else if (accept) begin
			r_valid <= 1'b1;
		end else if (entry_leaving) begin
			r_valid <= 1'b0;
		end
	end

	// entry payload, refilled on every accepted write
	always_ff @(posedge i_clk) begin
		if (accept) begin
			r_addr <= i_address;
			r_data <= i_write_data;
			r_strb <= i_byte_enable;
		end
	end

	assign o_wb_valid = r_valid;
	assign o_wb_addr  = r_addr;
	assign o_wb_data  = r_data;
	assign o_wb_strb  = r_strb;

endmodule

//--- hw/axi_master_bridge.sv
// AXI4 master turning buffered writes, core reads and line fills into bursts
`timescale 1ns/1ps

module axi_master_bridge
	import bus_pkg::*;
(
	input  logic   i_clk,
	input  logic   i_rst,
	// core and cache requests
	input  logic   i_select,
	input  logic   i_write_enable,
	input  logic   i_cache_req,
	input  addr_t  i_address,
	// write buffer
	input  logic   i_wb_valid,
	input  addr_t  i_wb_addr,
	input  word_t  i_wb_data,
	input  strb_t  i_wb_strb,
	output logic   o_wb_ready,
	// read returns
	output logic   o_read_stall,
	output word_t  o_read_data,
	output logic   o_stall_cache,
	output word_t  o_cache_rdata,
	output logic   o_cache_rvalid,
	// AXI4 write channels
	output logic   o_awvalid,
	input  logic   i_awready,
	output addr_t  o_awaddr,
	output len_t   o_awlen,
	output burst_t o_awburst,
	output logic   o_wvalid,
	input  logic   i_wready,
	output word_t  o_wdata,
	output strb_t  o_wstrb,
	output logic   o_wlast,
	input  logic   i_bvalid,
	output logic   o_bready,
	// AXI4 read channels
	output logic   o_arvalid,
	input  logic   i_arready,
	output addr_t  o_araddr,
	output len_t   o_arlen,
	output burst_t o_arburst,
	input  logic   i_rvalid,
	output logic   o_rready,
	input  word_t  i_rdata,
	input  logic   i_rlast
);

	bridge_state_t r_state;
	addr_t         r_addr;
	word_t         r_data;
	strb_t         r_strb;
	// current read is a cache line fill
	logic          r_fill;
	logic          core_rd;
	logic          beat;

	// core writes go through the buffer, so only reads matter here
	assign core_rd = i_select & ~i_write_enable;
	// a read beat is taken this cycle
	assign beat = (r_state == RD_DATA) & i_rvalid;

	// ========================================
	// transaction FSM
	// ========================================
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_state <= IDLE;
		end else begin
			case (r_state)
				// pending write first, then fill, then core read
				IDLE: begin
					if (i_wb_valid) begin
						r_state <= WR_ADDR;
					end else if (i_cache_req || core_rd) begin
						r_state <= RD_ADDR;
					end
				end
				WR_ADDR: if (i_awready) r_state <= WR_DATA;
				WR_DATA: if (i_wready) r_state <= WR_RESP;
				WR_RESP: if (i_bvalid) r_state <= IDLE;
				RD_ADDR: if (i_arready) r_state <= RD_DATA;
				RD_DATA: if (i_rvalid && i_rlast) r_state <= IDLE;
				default: r_state <= IDLE;
			endcase
		end
	end

	// capture the request so AXI outputs do not follow the held inputs
	always_ff @(posedge i_clk) begin
		if (r_state == IDLE) begin
			if (i_wb_valid) begin
				r_addr <= {i_wb_addr[31:2], 2'b00};
				r_data <= i_wb_data;
				r_strb <= i_wb_strb;
			end else begin
				// fills start at the critical word
				r_addr <= {i_address[31:2], 2'b00};
				r_fill <= i_cache_req;
			end
		end
	end

	// buffer entry is taken when the FSM is free
	assign o_wb_ready = (r_state == IDLE);

	// single-beat writes
	assign o_awvalid = (r_state == WR_ADDR);
	assign o_awaddr  = r_addr;
	assign o_awlen   = '0;
	assign o_awburst = BURST_INCR;
	assign o_wvalid  = (r_state == WR_DATA);
	assign o_wdata   = r_data;
	assign o_wstrb   = r_strb;
	assign o_wlast   = (r_state == WR_DATA);
	assign o_bready  = (r_state == WR_RESP);

	// fills wrap over one line, core reads are one beat
	assign o_arvalid = (r_state == RD_ADDR);
	assign o_araddr  = r_addr;
	assign o_arlen   = r_fill ? len_t'(LINE_WORDS - 1) : '0;
	assign o_arburst = r_fill ? BURST_WRAP : BURST_INCR;
	assign o_rready  = (r_state == RD_DATA);

	// core read completes on its only beat
	assign o_read_stall = core_rd & ~(beat & ~r_fill);
	assign o_read_data  = i_rdata;

	// every fill beat goes straight to the cache
	assign o_cache_rvalid = beat & r_fill;
	assign o_cache_rdata  = i_rdata;
	assign o_stall_cache  = i_cache_req & ~(beat & r_fill & i_rlast);

endmodule

//--- hw/axi_sram_slave.sv
// AXI4 slave on a word array with INCR and WRAP bursts and byte strobes
`timescale 1ns/1ps

module axi_sram_slave
	import bus_pkg::*;
#(
	parameter int MEM_ADDR_BITS = 10
) (
	input  logic   i_clk,
	input  logic   i_rst,
	// write channels
	input  logic   i_awvalid,
	output logic   o_awready,
	input  addr_t  i_awaddr,
	input  len_t   i_awlen,
	input  burst_t i_awburst,
	input  logic   i_wvalid,
	output logic   o_wready,
	input  word_t  i_wdata,
	input  strb_t  i_wstrb,
	input  logic   i_wlast,
	output logic   o_bvalid,
	input  logic   i_bready,
	// read channels
	input  logic   i_arvalid,
	output logic   o_arready,
	input  addr_t  i_araddr,
	input  len_t   i_arlen,
	input  burst_t i_arburst,
	output logic   o_rvalid,
	input  logic   i_rready,
	output word_t  o_rdata,
	output logic   o_rlast
);

	// word index into the array
	typedef logic [MEM_ADDR_BITS-1:0] widx_t;

	word_t  mem [0:(1 << MEM_ADDR_BITS) - 1];

	logic   r_wactive;
	logic   r_bvalid;
	widx_t  r_widx;
	len_t   r_wlen;
	burst_t r_wburst;
	logic   r_rvalid;
	widx_t  r_ridx;
	len_t   r_rlen;
	burst_t r_rburst;
	len_t   r_rcnt;
	word_t  r_rdata;
	widx_t  ridx_next;
	logic   r_hs;

	// next beat, wrapping inside a block of len+1 words
	function automatic widx_t next_idx(input widx_t idx, input len_t len, input burst_t burst);
		widx_t mask;
		mask = widx_t'(len);
		if (burst == BURST_WRAP) begin
			return (idx & ~mask) | ((idx + 1'b1) & mask);
		end
		return idx + 1'b1;
	endfunction

	// ========================================
	// write side
	// ========================================

	// address taken only when no burst or response is open
	assign o_awready = i_awvalid & ~r_wactive & ~r_bvalid;
	assign o_wready  = i_wvalid & r_wactive;
	assign o_bvalid  = r_bvalid;

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_wactive <= 1'b0;
			r_bvalid  <= 1'b0;
		end else begin
			if (o_awready) begin
				r_wactive <= 1'b1;
			end else if (o_wready && i_wlast) begin
				r_wactive <= 1'b0;
			end
			// one response per burst, held until taken
			if (o_wready && i_wlast) begin
				r_bvalid <= 1'b1;
			end else if (i_bready) begin
				r_bvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_awready) begin
			r_widx   <= i_awaddr[MEM_ADDR_BITS+1:2];
			r_wlen   <= i_awlen;
			r_wburst <= i_awburst;
		end else if (o_wready) begin
			r_widx <= next_idx(r_widx, r_wlen, r_wburst);
		end
	end

	// merge the enabled byte lanes into the stored word
	always_ff @(posedge i_clk) begin
		if (o_wready) begin
			for (int lane = 0; lane < 4; lane++) begin
				if (i_wstrb[lane]) begin
					mem[r_widx][8*lane +: 8] <= i_wdata[8*lane +: 8];
				end
			end
		end
	end

	// ========================================
	// read side
	// ========================================

	assign o_arready = i_arvalid & ~r_rvalid;
	assign r_hs      = r_rvalid & i_rready;
	assign ridx_next = next_idx(r_ridx, r_rlen, r_rburst);
	assign o_rvalid  = r_rvalid;
	assign o_rdata   = r_rdata;
	assign o_rlast   = (r_rcnt == r_rlen);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			r_rvalid <= 1'b0;
		end else if (o_arready) begin
			r_rvalid <= 1'b1;
		end else if (r_hs && o_rlast) begin
			r_rvalid <= 1'b0;
		end
	end

	// data only moves on a handshake, so it holds under back-pressure
	always_ff @(posedge i_clk) begin
		if (o_arready) begin
			r_ridx   <= i_araddr[MEM_ADDR_BITS+1:2];
			r_rlen   <= i_arlen;
			r_rburst <= i_arburst;
			r_rcnt   <= '0;
			r_rdata  <= mem[i_araddr[MEM_ADDR_BITS+1:2]];
		end else if (r_hs && !o_rlast) begin
			r_ridx  <= ridx_next;
			r_rcnt  <= r_rcnt + 1'b1;
			r_rdata <= mem[ridx_next];
		end
	end

endmodule

//--- hw/mem_subsys_top.sv
// memory subsystem top joining the write buffer, AXI bridge and SRAM slave
`timescale 1ns/1ps

module mem_subsys_top
	import bus_pkg::*;
#(
	parameter int MEM_ADDR_BITS = 10
) (
	input  logic  i_clk,
	input  logic  i_rst,
	// core port
	input  logic  i_select,
	input  logic  i_write_enable,
	input  addr_t i_address,
	input  word_t i_write_data,
	input  strb_t i_byte_enable,
	output logic  o_stall,
	output word_t o_read_data,
	// cache port
	input  logic  i_cache_req,
	output logic  o_stall_cache,
	output word_t o_cache_rdata,
	output logic  o_cache_rvalid
);

	logic   write_stall, read_stall;
	// buffer to bridge
	logic   wb_valid, wb_ready;
	addr_t  wb_addr;
	word_t  wb_data;
	strb_t  wb_strb;
	// AXI4 link
	logic   awvalid, awready, wvalid, wready, wlast, bvalid, bready;
	logic   arvalid, arready, rvalid, rready, rlast;
	addr_t  awaddr, araddr;
	len_t   awlen, arlen;
	burst_t awburst, arburst;
	word_t  wdata, rdata;
	strb_t  wstrb;

	// core waits on a full buffer or an unfinished read
	assign o_stall = write_stall | read_stall;

	core_write_buffer u_wbuf (
		.i_clk, .i_rst, .i_select, .i_write_enable, .i_address, .i_write_data,
		.i_byte_enable, .o_write_stall(write_stall), .i_wb_ready(wb_ready),
		.o_wb_valid(wb_valid), .o_wb_addr(wb_addr), .o_wb_data(wb_data),
		.o_wb_strb(wb_strb)
	);

	axi_master_bridge u_bridge (
		.i_clk, .i_rst, .i_select, .i_write_enable, .i_cache_req, .i_address,
		.i_wb_valid(wb_valid), .i_wb_addr(wb_addr), .i_wb_data(wb_data),
		.i_wb_strb(wb_strb), .o_wb_ready(wb_ready), .o_read_stall(read_stall),
		.o_read_data, .o_stall_cache, .o_cache_rdata, .o_cache_rvalid,
		.o_awvalid(awvalid), .i_awready(awready), .o_awaddr(awaddr), .o_awlen(awlen),
		.o_awburst(awburst), .o_wvalid(wvalid), .i_wready(wready), .o_wdata(wdata),
		.o_wstrb(wstrb), .o_wlast(wlast), .i_bvalid(bvalid), .o_bready(bready),
		.o_arvalid(arvalid), .i_arready(arready), .o_araddr(araddr), .o_arlen(arlen),
		.o_arburst(arburst), .i_rvalid(rvalid), .o_rready(rready), .i_rdata(rdata),
		.i_rlast(rlast)
	);

	axi_sram_slave #(.MEM_ADDR_BITS(MEM_ADDR_BITS)) u_sram (
		.i_clk, .i_rst,
		.i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr), .i_awlen(awlen),
		.i_awburst(awburst), .i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata),
		.i_wstrb(wstrb), .i_wlast(wlast), .o_bvalid(bvalid), .i_bready(bready),
		.i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr), .i_arlen(arlen),
		.i_arburst(arburst), .o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata),
		.o_rlast(rlast)
	);

endmodule

//--- testbench/mem_checker.sv
// checker that keeps a shadow memory and compares the core and cache port results
`timescale 1ns/1ps

module mem_checker
	import bus_pkg::*;
(
	input  logic  i_clk,
	input  logic  i_rst,
	input  logic  i_select,
	input  logic  i_write_enable,
	input  addr_t i_address,
	input  word_t i_write_data,
	input  strb_t i_byte_enable,
	input  logic  i_cache_req,
	input  logic  i_stall,
	input  word_t i_read_data,
	input  logic  i_stall_cache,
	input  word_t i_cache_rdata,
	input  logic  i_cache_rvalid,
	output int    o_checks,
	output int    o_errors
);

	// shadow of the first 64 words, the only ones the stimulus touches
	word_t shadow [0:63];
	int    n_checks = 0;
	int    n_errors = 0;
	int    beats = 0;
	// write buffer is known to be drained
	logic  buf_empty = 1'b1;

	assign o_checks = n_checks;
	assign o_errors = n_errors;

	// old word with every enabled byte lane replaced by the new byte
	function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input strb_t strb);
		word_t res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				res[8*b +: 8] = new_w[8*b +: 8];
			end
		end
		return res;
	endfunction

	// beat k of a fill wraps inside the 4-word line, k = 0 is a plain read
	function automatic word_t expect_word(input addr_t addr, input int k);
		logic [5:0] idx;
		idx = {addr[7:4], addr[3:2] + 2'(k)};
		return shadow[idx];
	endfunction

	task automatic flag_error(input string msg);
		n_errors++;
		$display("[ERROR] %0t: %s", $time, msg);
	endtask

	// ========================================
	// sampling in mid-cycle, inputs and outputs settled
	// ========================================
	always @(negedge i_clk) begin
		if (i_rst) begin
			buf_empty = 1'b1;
			beats = 0;
			n_checks++;
			if (i_stall_cache !== 1'b0 || i_cache_rvalid !== 1'b0) begin
				flag_error("cache stall or beat valid high during reset");
			end
		end else begin
			// idle cache port must stay quiet, this covers the cycles after reset
			if (!i_cache_req && (i_stall_cache !== 1'b0 || i_cache_rvalid !== 1'b0)) begin
				flag_error("cache stall or beat valid without a cache request");
			end
			if (i_select && i_write_enable) begin
				n_checks++;
				// posted write into an empty buffer never waits
				if (buf_empty && i_stall) begin
					flag_error($sformatf("write to %h stalled on an empty buffer", i_address));
				end
				if (!i_stall) begin
					shadow[i_address[7:2]] = merge_bytes(shadow[i_address[7:2]],
						i_write_data, i_byte_enable);
					buf_empty = 1'b0;
				end
			end
			if (i_select && !i_write_enable && !i_stall) begin
				n_checks++;
				if (i_read_data !== expect_word(i_address, 0)) begin
					flag_error($sformatf("read %h got %h expected %h", i_address,
						i_read_data, expect_word(i_address, 0)));
				end
				// reads wait behind the pending write
				buf_empty = 1'b1;
			end
			if (i_cache_rvalid) begin
				n_checks++;
				if (i_cache_rdata !== expect_word(i_address, beats)) begin
					flag_error($sformatf("fill %h beat %0d got %h expected %h", i_address,
						beats, i_cache_rdata, expect_word(i_address, beats)));
				end
				beats++;
			end
			// fill done, exactly one line of beats seen
			if (i_cache_req && !i_stall_cache) begin
				n_checks++;
				if (beats != LINE_WORDS) begin
					flag_error($sformatf("fill %h gave %0d beats", i_address, beats));
				end
				beats = 0;
				buf_empty = 1'b1;
			end
		end
	end

endmodule

//--- testbench/tb_mem_subsys.sv
// testbench driving LFSR stimulus into the memory subsystem core and cache ports
`timescale 1ns/1ps

module tb_mem_subsys;
	import bus_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RST_CYCLES = 8;
	localparam int MEM_WORDS = 64;
	localparam int LINE_TESTS = 16;
	localparam int RAND_OPS = 300;
	// every operation issued below, used by the watchdog
	localparam int NUM_OPS = MEM_WORDS + 2 + 2 * LINE_TESTS + RAND_OPS;

	logic  clk;
	logic  rst;
	logic  select;
	logic  write_enable;
	addr_t address;
	word_t write_data;
	strb_t byte_enable;
	logic  cache_req;
	logic  stall;
	word_t read_data;
	logic  stall_cache;
	word_t cache_rdata;
	logic  cache_rvalid;
	int    checks;
	int    errors;
	logic [31:0] lfsr_state = 32'd95651;

	mem_subsys_top #(.MEM_ADDR_BITS(10)) uut (
		.i_clk(clk), .i_rst(rst), .i_select(select), .i_write_enable(write_enable),
		.i_address(address), .i_write_data(write_data), .i_byte_enable(byte_enable),
		.o_stall(stall), .o_read_data(read_data), .i_cache_req(cache_req),
		.o_stall_cache(stall_cache), .o_cache_rdata(cache_rdata),
		.o_cache_rvalid(cache_rvalid)
	);

	mem_checker u_check (
		.i_clk(clk), .i_rst(rst), .i_select(select), .i_write_enable(write_enable),
		.i_address(address), .i_write_data(write_data), .i_byte_enable(byte_enable),
		.i_cache_req(cache_req), .i_stall(stall), .i_read_data(read_data),
		.i_stall_cache(stall_cache), .i_cache_rdata(cache_rdata),
		.i_cache_rvalid(cache_rvalid), .o_checks(checks), .o_errors(errors)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1, shifting left
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one LFSR step per bit taken
	task automatic draw_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[30:0], lfsr_state[0]};
		end
	endtask

	// word aligned, first 64 words only
	task automatic draw_addr(output addr_t a);
		logic [31:0] v;
		draw_bits(6, v);
		a = {24'b0, v[5:0], 2'b00};
	endtask

	// hold a core request until a cycle without stall, then release it
	task automatic core_access(input logic we, input addr_t a, input word_t d, input strb_t be);
		select = 1'b1;
		write_enable = we;
		address = a;
		write_data = d;
		byte_enable = be;
		do begin
			@(negedge clk);
		end while (stall);
		@(posedge clk);
		#1;
		select = 1'b0;
		write_enable = 1'b0;
	endtask

	// line fill ends with the last beat, when the cache stall drops
	task automatic cache_fill(input addr_t a);
		cache_req = 1'b1;
		address = a;
		do begin
			@(negedge clk);
		end while (stall_cache);
		@(posedge clk);
		#1;
		cache_req = 1'b0;
	endtask

	// ========================================
	// stimulus
	// ========================================
	initial begin
		addr_t       a;
		logic [31:0] d;
		logic [31:0] v;
		logic [31:0] op;
		rst = 1'b1;
		select = 1'b0;
		write_enable = 1'b0;
		address = '0;
		write_data = '0;
		byte_enable = '0;
		cache_req = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		// quiet cycles so the checker sees the state right after reset
		repeat (2) @(posedge clk);
		#1;
		// preload the whole window back to back, all lanes
		for (int i = 0; i < MEM_WORDS; i++) begin
			draw_bits(32, d);
			core_access(1'b1, addr_t'(i * 4), d, 4'hF);
		end
		// full word write followed by a read of the same word
		draw_addr(a);
		draw_bits(32, d);
		core_access(1'b1, a, d, 4'hF);
		core_access(1'b0, a, '0, '0);
		// masked write and then a fill of that line right behind it
		for (int i = 0; i < LINE_TESTS; i++) begin
			draw_addr(a);
			draw_bits(32, d);
			draw_bits(4, v);
			core_access(1'b1, a, d, v[3:0]);
			draw_bits(2, v);
			cache_fill({a[31:4], v[1:0], 2'b00});
		end
		// random mix of writes, reads and fills
		for (int i = 0; i < RAND_OPS; i++) begin
			draw_bits(2, op);
			draw_addr(a);
			draw_bits(32, d);
			draw_bits(4, v);
			case (op[1:0])
				2'd0: core_access(1'b1, a, d, 4'hF);
				2'd1: core_access(1'b1, a, d, v[3:0]);
				2'd2: core_access(1'b0, a, '0, '0);
				default: cache_fill(a);
			endcase
		end
		repeat (4) @(posedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && checks > 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// 40 cycles per operation covers a fill waiting behind a write
	initial begin
		#((NUM_OPS * 40 + RST_CYCLES) * CLK_PERIOD);
		$display("timeout, the DUT stopped answering before all operations were done");
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- filelist.f
hw/bus_pkg.sv
hw/core_write_buffer.sv
hw/axi_master_bridge.sv
hw/axi_sram_slave.sv
hw/mem_subsys_top.sv
testbench/mem_checker.sv
testbench/tb_mem_subsys.sv

//--- run_sim.sh
#!/bin/sh
# build the memory subsystem testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f filelist.f --top-module tb_mem_subsys \
	--Mdir obj_dir -o tb_sim > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "simulation passed" && exit 0
echo "simulation failed"
exit 1
